// File: include/fpv_settings.svh
`ifndef FPV_SETTINGS_SVH
`define FPV_SETTINGS_SVH

// Number of 64-bit lanes in the vector port.
`define FPV_LANES 2

// Width of one lane word.
`define FPV_LANE_W 64

// Full operand and result width.
`define FPV_DATA_W (`FPV_LANES * `FPV_LANE_W)

`endif

// File: hdl/fpv_pkg.sv
package fpv_pkg;

  typedef enum logic [3:0] {
    CMP_D  = 4'd0,
    CMP_S  = 4'd1,
    MIN_D  = 4'd2,
    MAX_D  = 4'd3,
    MIN_S  = 4'd4,
    MAX_S  = 4'd5,
    COPY_A = 4'd6,
    SWAP_S = 4'd7,
    DUP_S  = 4'd8
  } fpv_opcode_e;

  typedef enum logic [1:0] {EQ, LT, LE, UNORD} fpv_cmod_e;

  typedef enum logic [1:0] {CMP, MINMAX, PERM} fpv_kind_e;

  typedef enum logic [1:0] {PERM_COPY, PERM_SWAP, PERM_DUP} fpv_perm_e;

  typedef struct packed {
    fpv_opcode_e opcode;
    fpv_cmod_e   cmod;
  } fpv_instr_t;

  typedef struct packed {
    logic        sign;
    logic [10:0] exp;
    logic [51:0] frac;
  } fpv_dbl_t;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } fpv_sgl_t;

  // One lane word seen as a double or as two packed singles.
  typedef union packed {
    fpv_dbl_t       d;
    fpv_sgl_t [1:0] s;
  } fpv_word_u;

  typedef struct packed {
    fpv_kind_e kind;
    logic      is_dbl;
    logic      is_max;
    fpv_cmod_e cmod;
    fpv_perm_e perm;
    logic      illegal;
  } fpv_ctrl_t;

  typedef struct packed {
    fpv_word_u a;
    fpv_word_u b;
  } fpv_lane_in_t;

  typedef struct packed {
    fpv_word_u res;
    logic      invalid;
  } fpv_lane_out_t;

  // Canonical quiet NaNs.
  localparam fpv_dbl_t QNAN_D = '{sign: 1'b0, exp: 11'h7ff, frac: 52'h8_0000_0000_0000};
  localparam fpv_sgl_t QNAN_S = '{sign: 1'b0, exp: 8'hff, frac: 23'h40_0000};

endpackage

// File: hdl/fpv_decode.sv
`include "fpv_settings.svh"

module fpv_decode import fpv_pkg::*; (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  input  fpv_instr_t                    instr,
  input  fpv_word_u    [`FPV_LANES-1:0] a,
  input  fpv_word_u    [`FPV_LANES-1:0] b,
  output logic                          dec_valid,
  output fpv_ctrl_t                     dec_ctrl,
  output fpv_lane_in_t [`FPV_LANES-1:0] lane_in
);

  fpv_ctrl_t ctrl_next;

  // Opcode to lane controls.
  always_comb begin
    ctrl_next.kind    = PERM;
    ctrl_next.is_dbl  = 1'b0;
    ctrl_next.is_max  = 1'b0;
    ctrl_next.cmod    = instr.cmod;
    ctrl_next.perm    = PERM_COPY;
    ctrl_next.illegal = 1'b0;
    case (instr.opcode)
      CMP_D: begin
        ctrl_next.kind   = CMP;
        ctrl_next.is_dbl = 1'b1;
      end
      CMP_S: begin
        ctrl_next.kind = CMP;
      end
      MIN_D: begin
        ctrl_next.kind   = MINMAX;
        ctrl_next.is_dbl = 1'b1;
      end
      MAX_D: begin
        ctrl_next.kind   = MINMAX;
        ctrl_next.is_dbl = 1'b1;
        ctrl_next.is_max = 1'b1;
      end
      MIN_S: begin
        ctrl_next.kind = MINMAX;
      end
      MAX_S: begin
        ctrl_next.kind   = MINMAX;
        ctrl_next.is_max = 1'b1;
      end
      COPY_A: begin
        ctrl_next.perm = PERM_COPY;
      end
      SWAP_S: begin
        ctrl_next.perm = PERM_SWAP;
      end
      DUP_S: begin
        ctrl_next.perm = PERM_DUP;
      end
      default: begin
        ctrl_next.illegal = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= in_valid;
    end
  end

  // Controls and split operands are held between strobes.
  always_ff @(posedge clk) begin
    if (in_valid) begin
      dec_ctrl <= ctrl_next;
      for (int i = 0; i < `FPV_LANES; i++) begin
        lane_in[i].a <= a[i];
        lane_in[i].b <= b[i];
      end
    end
  end

endmodule

// File: hdl/fpv_lane.sv
`include "fpv_settings.svh"

module fpv_lane import fpv_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          dec_valid,
  input  fpv_ctrl_t     dec_ctrl,
  input  fpv_lane_in_t  lin,
  output logic          lane_valid,
  output fpv_lane_out_t lane_out,
  output logic          lane_illegal
);

  function automatic logic is_nan_d(input fpv_dbl_t x);
    return (x.exp == '1) && (x.frac != '0);
  endfunction

  function automatic logic is_nan_s(input fpv_sgl_t x);
    return (x.exp == '1) && (x.frac != '0);
  endfunction

  // Sign-adjusted order on exponent and fraction with zeros equal.
  function automatic logic ord_lt(input logic sa, input logic [62:0] ma,
                                  input logic sb, input logic [62:0] mb);
    logic lt;
    if ((ma == '0) && (mb == '0)) begin
      lt = 1'b0;
    end else if (sa != sb) begin
      lt = sa;
    end else if (sa) begin
      lt = ma > mb;
    end else begin
      lt = ma < mb;
    end
    return lt;
  endfunction

  function automatic logic ord_eq(input logic sa, input logic [62:0] ma,
                                  input logic sb, input logic [62:0] mb);
    return ((ma == '0) && (mb == '0)) || ((sa == sb) && (ma == mb));
  endfunction

  function automatic logic cmp_hold(input fpv_cmod_e cmod, input logic lt,
                                    input logic eq, input logic nan);
    logic hold;
    case (cmod)
      EQ:      hold = !nan && eq;
      LT:      hold = !nan && lt;
      LE:      hold = !nan && (lt || eq);
      default: hold = nan;
    endcase
    return hold;
  endfunction

  logic [62:0]    d_ma;
  logic [62:0]    d_mb;
  logic           d_nan;
  logic           d_lt;
  logic           d_gt;
  logic           d_hold;
  fpv_dbl_t       d_mm;
  logic [1:0]     s_nan;
  logic [1:0]     s_hold;
  fpv_sgl_t [1:0] s_mm;
  fpv_word_u      res_next;
  logic           inv_next;

  // Double view of the lane word.
  assign d_ma   = {lin.a.d.exp, lin.a.d.frac};
  assign d_mb   = {lin.b.d.exp, lin.b.d.frac};
  assign d_nan  = is_nan_d(lin.a.d) || is_nan_d(lin.b.d);
  assign d_lt   = ord_lt(lin.a.d.sign, d_ma, lin.b.d.sign, d_mb);
  assign d_gt   = ord_lt(lin.b.d.sign, d_mb, lin.a.d.sign, d_ma);
  assign d_hold = cmp_hold(dec_ctrl.cmod, d_lt,
                           ord_eq(lin.a.d.sign, d_ma, lin.b.d.sign, d_mb), d_nan);
  assign d_mm   = d_nan ? QNAN_D :
                  ((dec_ctrl.is_max ? d_lt : d_gt) ? lin.b.d : lin.a.d);

  // Packed-single view with one element per half.
  for (genvar i = 0; i < 2; i++) begin : g_sgl
    logic [62:0] ma;
    logic [62:0] mb;
    logic        lt;
    logic        gt;

    assign ma        = {32'b0, lin.a.s[i].exp, lin.a.s[i].frac};
    assign mb        = {32'b0, lin.b.s[i].exp, lin.b.s[i].frac};
    assign s_nan[i]  = is_nan_s(lin.a.s[i]) || is_nan_s(lin.b.s[i]);
    assign lt        = ord_lt(lin.a.s[i].sign, ma, lin.b.s[i].sign, mb);
    assign gt        = ord_lt(lin.b.s[i].sign, mb, lin.a.s[i].sign, ma);
    assign s_hold[i] = cmp_hold(dec_ctrl.cmod, lt,
                                ord_eq(lin.a.s[i].sign, ma, lin.b.s[i].sign, mb),
                                s_nan[i]);
    assign s_mm[i]   = s_nan[i] ? QNAN_S :
                       ((dec_ctrl.is_max ? lt : gt) ? lin.b.s[i] : lin.a.s[i]);
  end

  always_comb begin
    res_next = '0;
    inv_next = 1'b0;
    if (!dec_ctrl.illegal) begin
      case (dec_ctrl.kind)
        CMP: begin
          if (dec_ctrl.is_dbl) begin
            res_next = {`FPV_LANE_W{d_hold}};
          end else begin
            res_next.s = {{32{s_hold[1]}}, {32{s_hold[0]}}};
          end
          inv_next = dec_ctrl.is_dbl ? d_nan : |s_nan;
        end
        MINMAX: begin
          if (dec_ctrl.is_dbl) begin
            res_next.d = d_mm;
          end else begin
            res_next.s = s_mm;
          end
          inv_next = dec_ctrl.is_dbl ? d_nan : |s_nan;
        end
        PERM: begin
          case (dec_ctrl.perm)
            PERM_SWAP: res_next.s = {lin.a.s[0], lin.a.s[1]};
            PERM_DUP:  res_next.s = {lin.a.s[0], lin.a.s[0]};
            default:   res_next = lin.a;
          endcase
        end
        default: res_next = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= dec_valid;
    end
  end

  // Illegal travels with the result to the collector.
  always_ff @(posedge clk) begin
    if (dec_valid) begin
      lane_out.res     <= res_next;
      lane_out.invalid <= inv_next;
      lane_illegal     <= dec_ctrl.illegal;
    end
  end

endmodule

// File: hdl/fpv_collect.sv
`include "fpv_settings.svh"

module fpv_collect import fpv_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  input  logic          [`FPV_LANES-1:0] lane_valid,
  input  fpv_lane_out_t [`FPV_LANES-1:0] lane_out,
  input  logic                           illegal_in,
  input  logic                           trap_en,
  output logic                           out_valid,
  output logic          [`FPV_DATA_W-1:0] result,
  output logic                           invalid,
  output logic                           illegal,
  output logic                           exc_req
);

  logic                   all_valid;
  logic                   inv_any;
  logic [`FPV_DATA_W-1:0] res_cat;

  // Lanes run in lockstep.
  assign all_valid = &lane_valid;

  always_comb begin
    res_cat = '0;
    inv_any = 1'b0;
    for (int i = 0; i < `FPV_LANES; i++) begin
      res_cat[i*`FPV_LANE_W +: `FPV_LANE_W] = lane_out[i].res;
      inv_any = inv_any | lane_out[i].invalid;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      exc_req   <= 1'b0;
    end else begin
      out_valid <= all_valid;
      // Raised flags masked by the trap enable.
      exc_req   <= all_valid && trap_en && (inv_any || illegal_in);
    end
  end

  always_ff @(posedge clk) begin
    if (all_valid) begin
      result  <= res_cat;
      invalid <= inv_any;
      illegal <= illegal_in;
    end
  end

endmodule

// File: hdl/fpv_unit.sv
`include "fpv_settings.svh"

module fpv_unit import fpv_pkg::*; (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  input  fpv_instr_t                    instr,
  input  fpv_word_u [`FPV_LANES-1:0]    a,
  input  fpv_word_u [`FPV_LANES-1:0]    b,
  input  logic                          trap_en,
  output logic                          out_valid,
  output logic      [`FPV_DATA_W-1:0]   result,
  output logic                          invalid,
  output logic                          illegal,
  output logic                          exc_req
);

  logic                           dec_valid;
  fpv_ctrl_t                      dec_ctrl;
  fpv_lane_in_t  [`FPV_LANES-1:0] lane_in;
  logic          [`FPV_LANES-1:0] lane_valid;
  fpv_lane_out_t [`FPV_LANES-1:0] lane_out;
  logic          [`FPV_LANES-1:0] lane_illegal;

  fpv_decode u_decode (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .instr     (instr),
    .a         (a),
    .b         (b),
    .dec_valid (dec_valid),
    .dec_ctrl  (dec_ctrl),
    .lane_in   (lane_in)
  );

  for (genvar g = 0; g < `FPV_LANES; g++) begin : g_lane
    fpv_lane u_lane (
      .clk          (clk),
      .rst          (rst),
      .dec_valid    (dec_valid),
      .dec_ctrl     (dec_ctrl),
      .lin          (lane_in[g]),
      .lane_valid   (lane_valid[g]),
      .lane_out     (lane_out[g]),
      .lane_illegal (lane_illegal[g])
    );
  end

  // Illegal is common to all lanes and lane 0 carries it.
  fpv_collect u_collect (
    .clk        (clk),
    .rst        (rst),
    .lane_valid (lane_valid),
    .lane_out   (lane_out),
    .illegal_in (lane_illegal[0]),
    .trap_en    (trap_en),
    .out_valid  (out_valid),
    .result     (result),
    .invalid    (invalid),
    .illegal    (illegal),
    .exc_req    (exc_req)
  );

endmodule

// File: verif/fpv_clkgen.sv
module fpv_clkgen #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk;

endmodule

// File: verif/fpv_props.sv
`include "fpv_settings.svh"

module fpv_props (
  input logic                  clk,
  input logic                  rst,
  input logic                  in_valid,
  input logic                  dec_valid,
  input logic [`FPV_LANES-1:0] lane_valid,
  input logic                  out_valid,
  input logic                  exc_req
);

  int unsigned assert_errors = 0;

  // Fixed three-stage latency in both directions.
  a_latency: assert property (@(posedge clk) disable iff (rst) in_valid |-> ##3 out_valid)
    else begin
      $error("out_valid missing three cycles after in_valid");
      assert_errors++;
    end

  a_no_spurious: assert property (@(posedge clk) disable iff (rst)
                                  out_valid |-> $past(in_valid, 3))
    else begin
      $error("out_valid without a matching in_valid");
      assert_errors++;
    end

  a_exc_valid: assert property (@(posedge clk) disable iff (rst) exc_req |-> out_valid)
    else begin
      $error("exc_req high while out_valid low");
      assert_errors++;
    end

  a_reset: assert property (@(posedge clk)
                            rst |=> !dec_valid && (lane_valid == '0) && !out_valid && !exc_req)
    else begin
      $error("valid output high during reset");
      assert_errors++;
    end

endmodule

bind fpv_unit fpv_props u_props (
  .clk        (clk),
  .rst        (rst),
  .in_valid   (in_valid),
  .dec_valid  (dec_valid),
  .lane_valid (lane_valid),
  .out_valid  (out_valid),
  .exc_req    (exc_req)
);

// File: verif/tb_fpv_unit.sv
`include "fpv_settings.svh"

module tb_fpv_unit import fpv_pkg::*; ();

  localparam int PERIOD      = 8;
  localparam int DRIVE_DLY   = 1;
  localparam int N_INSTR     = 139;
  localparam int DRAIN_LIMIT = 8;
  // Reset, pipeline drains and the idle gaps of the mixed run.
  localparam int MAX_IDLE  = 2 + 6 * DRAIN_LIMIT + 3 * 24;
  localparam int WATCHDOG_TIME = (N_INSTR + MAX_IDLE + 20) * PERIOD;

  typedef struct packed {
    logic [`FPV_DATA_W-1:0] result;
    logic                   invalid;
    logic                   illegal;
    logic                   exc_req;
  } expect_t;

  typedef struct {
    expect_t exp;
    int      cycle;
    string   name;
  } pending_t;

  logic                       clk;
  logic                       rst;
  logic                       in_valid;
  fpv_instr_t                 instr;
  fpv_word_u [`FPV_LANES-1:0] a;
  fpv_word_u [`FPV_LANES-1:0] b;
  logic                       trap_en;
  logic                       out_valid;
  logic [`FPV_DATA_W-1:0]     result;
  logic                       invalid;
  logic                       illegal;
  logic                       exc_req;

  pending_t    exp_q[$];
  string       test_name = "reset";
  int          cycle = 0;
  int          issued = 0;
  int          checked = 0;
  int          out_count = 0;
  logic [15:0] lfsr_state = 16'd15858;

  fpv_clkgen #(.PERIOD(PERIOD)) u_clkgen (.clk(clk));

  fpv_unit UUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .instr     (instr),
    .a         (a),
    .b         (b),
    .trap_en   (trap_en),
    .out_valid (out_valid),
    .result    (result),
    .invalid   (invalid),
    .illegal   (illegal),
    .exc_req   (exc_req)
  );

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken.
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // Kind 0 is NaN, 1 is +0 and 2 is -0. Singles sit in the low half.
  function automatic logic [63:0] special_elem(input logic dbl, input int kind);
    logic [63:0] r;
    case (kind)
      0: begin
        if (dbl) begin
          r = rand_bits(52);
          return {r[51], 11'h7ff, r[50:0], 1'b1};
        end
        r = rand_bits(23);
        return {32'b0, r[22], 8'hff, r[21:0], 1'b1};
      end
      1: return 64'h0;
      default: return dbl ? 64'h8000_0000_0000_0000 : 64'h8000_0000;
    endcase
  endfunction

  function automatic logic elem_nan(input logic [63:0] e, input logic dbl);
    if (dbl) begin
      return (e[62:52] == 11'h7ff) && (e[51:0] != 52'h0);
    end
    return (e[30:23] == 8'hff) && (e[22:0] != 23'h0);
  endfunction

  // Sign-magnitude mapped onto a signed line where -0 and +0 meet.
  function automatic logic signed [64:0] order_key(input logic [63:0] e, input logic dbl);
    logic        s;
    logic [62:0] m;
    s = dbl ? e[63] : e[31];
    m = dbl ? e[62:0] : {32'b0, e[30:0]};
    return s ? -$signed({2'b0, m}) : $signed({2'b0, m});
  endfunction

  function automatic logic cmp_holds(input fpv_cmod_e c, input logic signed [64:0] ka,
                                     input logic signed [64:0] kb, input logic unord);
    case (c)
      EQ:      return !unord && (ka == kb);
      LT:      return !unord && (ka < kb);
      LE:      return !unord && (ka <= kb);
      default: return unord;
    endcase
  endfunction

  function automatic expect_t fpv_model(input fpv_instr_t ins,
                                        input fpv_word_u [`FPV_LANES-1:0] wa,
                                        input fpv_word_u [`FPV_LANES-1:0] wb,
                                        input logic trap);
    expect_t            e;
    int                 kind;
    logic               dbl;
    logic               is_max;
    logic               unord;
    logic [63:0]        av;
    logic [63:0]        bv;
    logic [63:0]        rv;
    logic [63:0]        ea;
    logic [63:0]        eb;
    logic [63:0]        el;
    logic signed [64:0] ka;
    logic signed [64:0] kb;
    e = '0;
    dbl = 1'b0;
    is_max = 1'b0;
    case (ins.opcode)
      CMP_D: begin
        kind = 0;
        dbl = 1'b1;
      end
      CMP_S: kind = 0;
      MIN_D: begin
        kind = 1;
        dbl = 1'b1;
      end
      MAX_D: begin
        kind = 1;
        dbl = 1'b1;
        is_max = 1'b1;
      end
      MIN_S: kind = 1;
      MAX_S: begin
        kind = 1;
        is_max = 1'b1;
      end
      COPY_A: kind = 2;
      SWAP_S: kind = 3;
      DUP_S: kind = 4;
      default: kind = 5;
    endcase
    for (int l = 0; l < `FPV_LANES; l++) begin
      av = wa[l];
      bv = wb[l];
      rv = '0;
      if (kind <= 1) begin
        for (int i = 0; i < (dbl ? 1 : 2); i++) begin
          ea = dbl ? av : {32'b0, av[32*i +: 32]};
          eb = dbl ? bv : {32'b0, bv[32*i +: 32]};
          ka = order_key(ea, dbl);
          kb = order_key(eb, dbl);
          unord = elem_nan(ea, dbl) || elem_nan(eb, dbl);
          e.invalid |= unord;
          if (kind == 0) begin
            el = {64{cmp_holds(ins.cmod, ka, kb, unord)}};
          end else if (unord) begin
            el = dbl ? 64'h7ff8_0000_0000_0000 : 64'h7fc0_0000;
          end else if (is_max ? (kb > ka) : (kb < ka)) begin
            el = eb;
          end else begin
            el = ea;
          end
          if (dbl) begin
            rv = el;
          end else begin
            rv[32*i +: 32] = el[31:0];
          end
        end
      end else if (kind == 2) begin
        rv = av;
      end else if (kind == 3) begin
        rv = {av[31:0], av[63:32]};
      end else if (kind == 4) begin
        rv = {av[31:0], av[31:0]};
      end
      e.result[64*l +: 64] = rv;
    end
    e.illegal = (kind == 5);
    e.exc_req = trap && (e.invalid || e.illegal);
    return e;
  endfunction

  task automatic halt_run();
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_result(input string test, input logic [`FPV_DATA_W-1:0] exp,
                              input logic [`FPV_DATA_W-1:0] act);
    if (exp !== act) begin
      $display("Fail %s result: expected %h, actual %h", test, exp, act);
      halt_run();
    end
  endtask

  task automatic check_flag(input string test, input string what, input logic exp,
                            input logic act);
    if (exp !== act) begin
      $display("Fail %s %s: expected %b, actual %b", test, what, exp, act);
      halt_run();
    end
  endtask

  task automatic check_count(input string test, input string what, input int exp,
                             input int act);
    if (exp != act) begin
      $display("Fail %s %s: expected %0d, actual %0d", test, what, exp, act);
      halt_run();
    end
  endtask

  // Random words with NaN, signed zero and tie elements mixed in.
  task automatic make_operands(input logic dbl, output fpv_word_u [`FPV_LANES-1:0] wa,
                               output fpv_word_u [`FPV_LANES-1:0] wb);
    logic [63:0] ra;
    logic [63:0] rb;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] mode;
    for (int l = 0; l < `FPV_LANES; l++) begin
      ra = rand_bits(64);
      rb = rand_bits(64);
      for (int i = 0; i < (dbl ? 1 : 2); i++) begin
        mode = rand_bits(3);
        ea = dbl ? ra : {32'b0, ra[32*i +: 32]};
        eb = dbl ? rb : {32'b0, rb[32*i +: 32]};
        case (mode[2:0])
          3'd3: eb = ea;
          3'd4: ea = special_elem(dbl, 0);
          3'd5: eb = special_elem(dbl, 0);
          3'd6: begin
            ea = special_elem(dbl, 1);
            eb = special_elem(dbl, 2);
          end
          3'd7: ea = special_elem(dbl, 2);
          default: ;
        endcase
        if (dbl) begin
          ra = ea;
          rb = eb;
        end else begin
          ra[32*i +: 32] = ea[31:0];
          rb[32*i +: 32] = eb[31:0];
        end
      end
      wa[l] = ra;
      wb[l] = rb;
    end
  endtask

  task automatic issue_ops(input fpv_opcode_e op, input fpv_cmod_e cm,
                           input fpv_word_u [`FPV_LANES-1:0] wa,
                           input fpv_word_u [`FPV_LANES-1:0] wb);
    pending_t p;
    @(posedge clk);
    #DRIVE_DLY;
    in_valid = 1'b1;
    instr = '{opcode: op, cmod: cm};
    a = wa;
    b = wb;
    p.exp = fpv_model(instr, wa, wb, trap_en);
    p.cycle = cycle;
    p.name = test_name;
    exp_q.push_back(p);
    issued++;
  endtask

  task automatic issue(input fpv_opcode_e op, input fpv_cmod_e cm, input logic dbl);
    fpv_word_u [`FPV_LANES-1:0] wa;
    fpv_word_u [`FPV_LANES-1:0] wb;
    make_operands(dbl, wa, wb);
    issue_ops(op, cm, wa, wb);
  endtask

  task automatic idle();
    @(posedge clk);
    #DRIVE_DLY;
    in_valid = 1'b0;
  endtask

  task automatic drain();
    int waits;
    waits = 0;
    idle();
    while ((checked != issued) && (waits < DRAIN_LIMIT)) begin
      @(posedge clk);
      waits++;
    end
  endtask

  task automatic set_trap(input logic v);
    @(posedge clk);
    #DRIVE_DLY;
    trap_en = v;
  endtask

  // Compare on the falling edge away from the register updates.
  always @(negedge clk) begin : compare
    pending_t p;
    if (!rst && (out_valid === 1'b1)) begin
      out_count++;
      if (exp_q.size() == 0) begin
        $display("out_valid went high with no instruction in flight.");
        halt_run();
      end else begin
        p = exp_q.pop_front();
        check_result(p.name, p.exp.result, result);
        check_flag(p.name, "invalid", p.exp.invalid, invalid);
        check_flag(p.name, "illegal", p.exp.illegal, illegal);
        check_flag(p.name, "exc_req", p.exp.exc_req, exc_req);
        check_count(p.name, "latency", 3, cycle - p.cycle);
        checked++;
      end
    end
    if (UUT.u_props.assert_errors != 0) begin
      $display("A bound assertion on the DUT failed.");
      halt_run();
    end
  end

  initial begin : watchdog
    #(WATCHDOG_TIME);
    $display("Timeout: not all results arrived within %0d time units.", WATCHDOG_TIME);
    halt_run();
  end

  initial begin : stimulus
    fpv_word_u [`FPV_LANES-1:0] za;
    fpv_word_u [`FPV_LANES-1:0] zb;
    fpv_word_u [`FPV_LANES-1:0] na;
    logic [63:0]                r;
    rst = 1'b1;
    in_valid = 1'b0;
    instr = '0;
    a = '0;
    b = '0;
    trap_en = 1'b0;
    za = '0;
    zb = {64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000};
    na = {64'h7ff0_0000_0000_0001, 64'h0000_0000_7fc0_0001};
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    test_name = "compare";
    for (int c = 0; c < 4; c++) begin
      for (int rep = 0; rep < 6; rep++) begin
        issue(CMP_D, fpv_cmod_e'(c), 1'b1);
        issue(CMP_S, fpv_cmod_e'(c), 1'b0);
      end
    end
    issue_ops(CMP_D, EQ, za, zb);
    issue_ops(CMP_S, UNORD, na, za);
    drain();

    test_name = "min_max";
    for (int rep = 0; rep < 8; rep++) begin
      issue(MIN_D, EQ, 1'b1);
      issue(MAX_D, EQ, 1'b1);
      issue(MIN_S, EQ, 1'b0);
      issue(MAX_S, EQ, 1'b0);
    end
    issue_ops(MAX_D, EQ, na, zb);
    drain();

    test_name = "permute";
    for (int rep = 0; rep < 4; rep++) begin
      issue(COPY_A, EQ, 1'b0);
      issue(SWAP_S, EQ, 1'b0);
      issue(DUP_S, EQ, 1'b0);
    end
    drain();

    // Same flag cases with the trap masked and then enabled.
    for (int t = 0; t < 2; t++) begin
      test_name = (t == 0) ? "illegal_trap_off" : "illegal_trap_on";
      set_trap(t[0]);
      for (int o = 9; o < 16; o++) begin
        issue(fpv_opcode_e'(o), EQ, 1'b0);
      end
      issue_ops(CMP_D, UNORD, na, za);
      issue(MIN_S, LT, 1'b0);
      issue(MAX_D, LE, 1'b1);
      drain();
    end

    test_name = "mixed";
    for (int n = 0; n < 24; n++) begin
      r = rand_bits(9);
      issue(fpv_opcode_e'(r[3:0]), fpv_cmod_e'(r[5:4]), r[8]);
      repeat (r[7:6]) idle();
    end
    drain();

    test_name = "totals";
    check_count(test_name, "results seen", issued, out_count);
    if (UUT.u_props.assert_errors == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("A bound assertion on the DUT failed.");
      halt_run();
    end
  end

endmodule

// File: files.f
+incdir+include
hdl/fpv_pkg.sv
hdl/fpv_decode.sv
hdl/fpv_lane.sv
hdl/fpv_collect.sv
hdl/fpv_unit.sv
verif/fpv_clkgen.sv
verif/fpv_props.sv
verif/tb_fpv_unit.sv
